// File: all.f
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// File: rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_alu (
	input  logic                clk,
	input  logic                rstn,
	input  rv_pkg::alu_op_e     op,
	input  logic [`RV_XLEN-1:0] a,
	input  logic [`RV_XLEN-1:0] b,
	output logic [`RV_XLEN-1:0] result
);

	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			case (op)
				alu_add:  result <= a + b;
				alu_sub:  result <= a - b;
				alu_sll:  result <= a << shamt;
				alu_slt:  result <= `RV_XLEN'($signed(a) < $signed(b));
				alu_sltu: result <= `RV_XLEN'(a < b);
				alu_xor:  result <= a ^ b;
				alu_srl:  result <= a >> shamt;
				alu_sra:  result <= $signed(a) >>> shamt;
				alu_or:   result <= a | b;
				alu_and:  result <= a & b;
				// branch compares, bit 0 is taken
				alu_beq:  result <= `RV_XLEN'(a == b);
				alu_bne:  result <= `RV_XLEN'(a != b);
				alu_blt:  result <= `RV_XLEN'($signed(a) < $signed(b));
				alu_bge:  result <= `RV_XLEN'($signed(a) >= $signed(b));
				alu_bltu: result <= `RV_XLEN'(a < b);
				alu_bgeu: result <= `RV_XLEN'(a >= b);
				default:  result <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_core (
	input  logic                 clk,
	input  logic                 rstn,
	output logic                 imem_valid,
	input  logic                 imem_ready,
	output logic [`RV_XLEN-1:0]  imem_addr,
	input  logic                 imem_rsp_valid,
	input  logic [`RV_XLEN-1:0]  imem_rdata,
	output logic                 dmem_valid,
	input  logic                 dmem_ready,
	output logic [`RV_XLEN-1:0]  dmem_addr,
	output logic                 dmem_write,
	output logic [`RV_LANES-1:0] dmem_strb,
	output logic [`RV_XLEN-1:0]  dmem_wdata,
	input  logic                 dmem_rsp_valid,
	input  logic [`RV_XLEN-1:0]  dmem_rdata,
	output logic                 halted
);

	import rv_pkg::*;

	core_state_e                state;
	inst_word_t                 inst;
	alu_op_e                    alu_op;
	mem_size_e                  mem_size;
	logic [`RV_REG_IDX_W-1:0]   rs1, rs2, rd;
	logic [`RV_XLEN-1:0]        pc, next_pc, imm, rdata1, rdata2, alu_b, alu_result;
	logic [`RV_XLEN-1:0]        load_data, mem_addr, pc_imm, pc_plus4, wb_data;
	logic                       fetch_start, pc_load, inst_done, reg_we, mem_start, mem_done;
	logic                       use_imm, writes_rd, is_load, is_store, mem_unsigned;
	logic                       is_branch, is_jal, is_jalr, is_lui, is_auipc, is_ecall;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_fetch;
		end else begin
			case (state)
				st_fetch:  if (inst_done) state <= st_decode;
				st_decode: state <= st_read;
				st_read:   state <= st_exec;
				st_exec:   state <= (is_load || is_store) ? st_mem : st_write;
				st_mem:    if (mem_done) state <= st_write;
				st_write:  state <= is_ecall ? st_halt : st_fetch;
				st_halt:   state <= st_halt;
				default:   state <= st_fetch;
			endcase
		end
	end

	assign fetch_start = (state == st_fetch) && !inst_done; // no restart on the done cycle
	assign mem_start   = (state == st_exec) && (is_load || is_store);
	assign reg_we      = (state == st_write) && writes_rd;
	assign pc_load     = (state == st_write);
	assign halted      = (state == st_halt);

	assign alu_b    = use_imm ? imm : rdata2;
	assign mem_addr = rdata1 + imm; // also the jalr target
	assign pc_imm   = pc + imm;
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		if (is_jal || (is_branch && alu_result[0]))
			next_pc = pc_imm;
		else if (is_jalr)
			next_pc = {mem_addr[`RV_XLEN-1:1], 1'b0};
		else
			next_pc = pc_plus4;
	end

	always_comb begin
		if (is_lui)
			wb_data = imm;
		else if (is_auipc)
			wb_data = pc_imm;
		else if (is_jal || is_jalr)
			wb_data = pc_plus4; // link
		else if (is_load)
			wb_data = load_data;
		else
			wb_data = alu_result;
	end

	rv_fetch u_fetch (
		.clk(clk), .rstn(rstn), .fetch_start(fetch_start), .pc_load(pc_load),
		.next_pc(next_pc), .pc(pc), .inst(inst), .inst_done(inst_done),
		.imem_valid(imem_valid), .imem_ready(imem_ready), .imem_addr(imem_addr),
		.imem_rsp_valid(imem_rsp_valid), .imem_rdata(imem_rdata)
	);

	rv_decode u_decode (
		.clk(clk), .rstn(rstn), .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.alu_op(alu_op), .use_imm(use_imm), .writes_rd(writes_rd), .is_load(is_load),
		.is_store(is_store), .mem_size(mem_size), .mem_unsigned(mem_unsigned),
		.is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .is_lui(is_lui),
		.is_auipc(is_auipc), .is_ecall(is_ecall)
	);

	rv_regfile u_regfile (
		.clk(clk), .rstn(rstn), .rs1(rs1), .rs2(rs2), .rd(rd), .we(reg_we),
		.wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
	);

	rv_alu u_alu (
		.clk(clk), .rstn(rstn), .op(alu_op), .a(rdata1), .b(alu_b), .result(alu_result)
	);

	rv_lsu u_lsu (
		.clk(clk), .rstn(rstn), .mem_start(mem_start), .is_store(is_store),
		.size(mem_size), .is_unsigned(mem_unsigned), .addr(mem_addr),
		.store_data(rdata2), .load_data(load_data), .mem_done(mem_done),
		.dmem_valid(dmem_valid), .dmem_ready(dmem_ready), .dmem_addr(dmem_addr),
		.dmem_write(dmem_write), .dmem_strb(dmem_strb), .dmem_wdata(dmem_wdata),
		.dmem_rsp_valid(dmem_rsp_valid), .dmem_rdata(dmem_rdata)
	);

endmodule

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_decode (
	input  logic                     clk,
	input  logic                     rstn,
	input  rv_pkg::inst_word_t       inst,
	output logic [`RV_REG_IDX_W-1:0] rs1,
	output logic [`RV_REG_IDX_W-1:0] rs2,
	output logic [`RV_REG_IDX_W-1:0] rd,
	output logic [`RV_XLEN-1:0]      imm,
	output rv_pkg::alu_op_e          alu_op,
	output logic                     use_imm,
	output logic                     writes_rd,
	output logic                     is_load,
	output logic                     is_store,
	output rv_pkg::mem_size_e        mem_size,
	output logic                     mem_unsigned,
	output logic                     is_branch,
	output logic                     is_jal,
	output logic                     is_jalr,
	output logic                     is_lui,
	output logic                     is_auipc,
	output logic                     is_ecall
);

	import rv_pkg::*;

	opcode_e              opc;
	logic [2:0]           f3;
	logic [6:0]           f7;
	logic [`RV_XLEN-1:0]  imm_n;
	alu_op_e              alu_op_n;
	logic                 use_imm_n, wr_n, ld_n, st_n, br_n;
	logic                 jal_n, jalr_n, lui_n, auipc_n, ecall_n;

	assign opc = opcode_e'(inst.r_fmt.opcode);
	assign f3  = inst.r_fmt.funct3;
	assign f7  = inst.r_fmt.funct7;

	function automatic alu_op_e arith_op(input logic [2:0] fn, input logic alt);
		case (fn)
			3'b000:  return alt ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return alt ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	function automatic alu_op_e branch_op(input logic [2:0] fn);
		case (fn)
			3'b000:  return alu_beq;
			3'b001:  return alu_bne;
			3'b100:  return alu_blt;
			3'b101:  return alu_bge;
			3'b110:  return alu_bltu;
			default: return alu_bgeu;
		endcase
	endfunction

	always_comb begin
		imm_n     = '0;
		alu_op_n  = alu_add;
		use_imm_n = 1'b0;
		wr_n      = 1'b0;
		ld_n      = 1'b0;
		st_n      = 1'b0;
		br_n      = 1'b0;
		jal_n     = 1'b0;
		jalr_n    = 1'b0;
		lui_n     = 1'b0;
		auipc_n   = 1'b0;
		ecall_n   = 1'b0;
		case (opc)
			op_lui, op_auipc: begin
				imm_n   = {inst.u_fmt.imm_31_12, 12'b0};
				wr_n    = 1'b1;
				lui_n   = (opc == op_lui);
				auipc_n = (opc == op_auipc);
			end
			op_jal: begin
				imm_n = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
					inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
				wr_n  = 1'b1;
				jal_n = 1'b1;
			end
			op_jalr: begin
				imm_n  = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
				wr_n   = (f3 == 3'b000);
				jalr_n = (f3 == 3'b000);
			end
			op_branch: begin
				imm_n    = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
					inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
				alu_op_n = branch_op(f3);
				br_n     = (f3[2:1] != 2'b01);
			end
			op_load: begin
				imm_n     = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
				use_imm_n = 1'b1;
				ld_n      = (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b010 ||
					f3 == 3'b100 || f3 == 3'b101);
				wr_n      = ld_n;
			end
			op_store: begin
				imm_n     = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
				use_imm_n = 1'b1;
				st_n      = !f3[2] && (f3[1:0] != 2'b11);
			end
			op_imm: begin
				imm_n     = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
				use_imm_n = 1'b1;
				alu_op_n  = arith_op(f3, (f3 == 3'b101) && f7[5]); // funct7 is imm for the rest
				wr_n      = (f3 == 3'b001) ? (f7 == 7'b0) :
					(f3 == 3'b101) ? (f7 == 7'b0 || f7 == 7'b0100000) : 1'b1;
			end
			op_reg: begin
				alu_op_n = arith_op(f3, f7[5]);
				wr_n     = (f7 == 7'b0) ||
					(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
			end
			op_system: ecall_n = (inst == 32'h0000_0073);
			default: ; // unknown word retires as a no-op
		endcase
	end

	always_ff @(posedge clk) begin
		rs1          <= inst.r_fmt.rs1;
		rs2          <= inst.r_fmt.rs2;
		rd           <= inst.r_fmt.rd;
		imm          <= imm_n;
		mem_size     <= mem_size_e'(f3[1:0]);
		mem_unsigned <= f3[2];
		if (!rstn) begin
			alu_op    <= alu_add;
			use_imm   <= 1'b0;
			writes_rd <= 1'b0;
			is_load   <= 1'b0;
			is_store  <= 1'b0;
			is_branch <= 1'b0;
			is_jal    <= 1'b0;
			is_jalr   <= 1'b0;
			is_lui    <= 1'b0;
			is_auipc  <= 1'b0;
			is_ecall  <= 1'b0;
		end else begin
			alu_op    <= alu_op_n;
			use_imm   <= use_imm_n;
			writes_rd <= wr_n && (inst.r_fmt.rd != '0);
			is_load   <= ld_n;
			is_store  <= st_n;
			is_branch <= br_n;
			is_jal    <= jal_n;
			is_jalr   <= jalr_n;
			is_lui    <= lui_n;
			is_auipc  <= auipc_n;
			is_ecall  <= ecall_n;
		end
	end

endmodule

`default_nettype wire

// File: rv_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_fetch (
	input  logic                clk,
	input  logic                rstn,
	input  logic                fetch_start,
	input  logic                pc_load,
	input  logic [`RV_XLEN-1:0] next_pc,
	output logic [`RV_XLEN-1:0] pc,
	output rv_pkg::inst_word_t  inst,
	output logic                inst_done,
	output logic                imem_valid,
	input  logic                imem_ready,
	output logic [`RV_XLEN-1:0] imem_addr,
	input  logic                imem_rsp_valid,
	input  logic [`RV_XLEN-1:0] imem_rdata
);

	logic waiting; // request taken, response pending
	logic issue;

	assign issue = fetch_start && !imem_valid && !waiting;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc         <= `RV_RESET_PC;
			imem_valid <= 1'b0;
			waiting    <= 1'b0;
			inst_done  <= 1'b0;
		end else begin
			inst_done <= 1'b0;
			if (pc_load)
				pc <= next_pc;
			if (issue)
				imem_valid <= 1'b1;
			if (imem_valid && imem_ready) begin
				imem_valid <= 1'b0;
				waiting    <= 1'b1;
			end
			if (waiting && imem_rsp_valid) begin
				waiting   <= 1'b0;
				inst_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			imem_addr <= pc; // held until the handshake
		if (waiting && imem_rsp_valid)
			inst <= imem_rdata;
	end

endmodule

`default_nettype wire

// File: rv_lsu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_lsu (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 mem_start,
	input  logic                 is_store,
	input  rv_pkg::mem_size_e    size,
	input  logic                 is_unsigned,
	input  logic [`RV_XLEN-1:0]  addr,
	input  logic [`RV_XLEN-1:0]  store_data,
	output logic [`RV_XLEN-1:0]  load_data,
	output logic                 mem_done,
	output logic                 dmem_valid,
	input  logic                 dmem_ready,
	output logic [`RV_XLEN-1:0]  dmem_addr,
	output logic                 dmem_write,
	output logic [`RV_LANES-1:0] dmem_strb,
	output logic [`RV_XLEN-1:0]  dmem_wdata,
	input  logic                 dmem_rsp_valid,
	input  logic [`RV_XLEN-1:0]  dmem_rdata
);

	import rv_pkg::*;

	localparam int off_w = $clog2(`RV_LANES);

	logic                waiting;
	logic [off_w-1:0]    off;     // lane of the first byte
	logic [off_w-1:0]    off_q;
	mem_size_e           size_q;
	logic                uns_q;
	logic [`RV_LANES-1:0] strb_n;
	logic [`RV_XLEN-1:0] wdata_n;
	logic [`RV_XLEN-1:0] lane_word;
	logic [`RV_XLEN-1:0] ext_data;

	// misaligned low bits are dropped
	always_comb begin
		case (size)
			size_byte: off = addr[off_w-1:0];
			size_half: off = {addr[off_w-1:1], 1'b0};
			default:   off = '0;
		endcase
	end

	always_comb begin
		case (size)
			size_byte: begin
				strb_n  = {1'b1, {(`RV_LANES-1){1'b0}}} >> off;
				wdata_n = {store_data[7:0], {(`RV_XLEN-8){1'b0}}} >> {off, 3'b000};
			end
			size_half: begin
				strb_n  = {2'b11, {(`RV_LANES-2){1'b0}}} >> off;
				wdata_n = {store_data[15:0], {(`RV_XLEN-16){1'b0}}} >> {off, 3'b000};
			end
			default: begin
				strb_n  = '1;
				wdata_n = store_data;
			end
		endcase
	end

	// bring the addressed lane to the top
	assign lane_word = dmem_rdata << {off_q, 3'b000};

	always_comb begin
		case (size_q)
			size_byte: ext_data = uns_q ? {{(`RV_XLEN-8){1'b0}}, lane_word[`RV_XLEN-1 -: 8]} :
				{{(`RV_XLEN-8){lane_word[`RV_XLEN-1]}}, lane_word[`RV_XLEN-1 -: 8]};
			size_half: ext_data = uns_q ? {{(`RV_XLEN-16){1'b0}}, lane_word[`RV_XLEN-1 -: 16]} :
				{{(`RV_XLEN-16){lane_word[`RV_XLEN-1]}}, lane_word[`RV_XLEN-1 -: 16]};
			default:   ext_data = dmem_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dmem_valid <= 1'b0;
			waiting    <= 1'b0;
			mem_done   <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			if (mem_start && !dmem_valid && !waiting)
				dmem_valid <= 1'b1;
			if (dmem_valid && dmem_ready) begin
				dmem_valid <= 1'b0;
				waiting    <= 1'b1;
			end
			if (waiting && dmem_rsp_valid) begin
				waiting  <= 1'b0;
				mem_done <= 1'b1;
			end
		end
	end

	// request fields stay put until the handshake
	always_ff @(posedge clk) begin
		if (mem_start && !dmem_valid && !waiting) begin
			dmem_addr  <= {addr[`RV_XLEN-1:off_w], {off_w{1'b0}}};
			dmem_write <= is_store;
			dmem_strb  <= strb_n;
			dmem_wdata <= wdata_n;
			off_q      <= off;
			size_q     <= size;
			uns_q      <= is_unsigned;
		end
		if (waiting && dmem_rsp_valid)
			load_data <= ext_data;
	end

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, six views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_word_t;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_system = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
	} alu_op_e;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} mem_size_e;

	typedef enum logic [2:0] {
		st_fetch, st_decode, st_read, st_exec, st_mem, st_write, st_halt
	} core_state_e;

endpackage

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_regfile (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [`RV_REG_IDX_W-1:0] rs1,
	input  logic [`RV_REG_IDX_W-1:0] rs2,
	input  logic [`RV_REG_IDX_W-1:0] rd,
	input  logic                     we,
	input  logic [`RV_XLEN-1:0]      wdata,
	output logic [`RV_XLEN-1:0]      rdata1,
	output logic [`RV_XLEN-1:0]      rdata2
);

	logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < `RV_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[rd] <= wdata;
		end
	end

	// x0 is forced on the read side
	always_ff @(posedge clk) begin
		rdata1 <= (rs1 == '0) ? '0 : regs[rs1];
		rdata2 <= (rs2 == '0) ? '0 : regs[rs2];
	end

endmodule

`default_nettype wire

// File: rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// integer register file
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// byte lanes per data word, lane 0 is the MSB byte
`define RV_LANES 4

`endif

// File: tb_golden.txt
// @000 program words by word address; @080 initial data words by word address
// @0c0 store count, then one store per line: address data strobe; @180 fetch count, addresses
@000
FFB00093 00300113 002081B3 04302023 40110233 04402223 002092B3 4020D333
0020D3B3 0020A433 0020B4B3 0020C533 0020E5B3 0020F633 04502423 04602623
04702823 04802A23 04902C23 04A02E23 06B02023 06C02223 123456B7 00001717
06D02423 06E02623 00208463 00209463 06300793 0020C463 06300793 0020F463
06300793 0020E463 0020D463 00C0086F 06300793 06300793 0A0008E7 06300793
06F02823 07002A23 07102C23 081000A3 08101323 02100903 02104983 02201A03
02005A83 02002B03 09202423 09302623 09402823 09502A23 09602C23 00000073
@088
80F17F22
@0c0
00000016
00000040 FFFFFFFE F
00000044 00000008 F
00000048 FFFFFFD8 F
0000004C FFFFFFFF F
00000050 1FFFFFFF F
00000054 00000001 F
00000058 00000000 F
0000005C FFFFFFF8 F
00000060 FFFFFFFB F
00000064 00000003 F
00000068 12345000 F
0000006C 0000105C F
00000070 00000000 F
00000074 00000090 F
00000078 0000009C F
00000080 00FB0000 4
00000084 0000FFFB 3
00000088 FFFFFFF1 F
0000008C 000000F1 F
00000090 00007F22 F
00000094 000080F1 F
00000098 80F17F22 F
@180
00000032
00 04 08 0C 10 14 18 1C 20 24 28 2C 30 34 38 3C
40 44 48 4C 50 54 58 5C 60 64 68 6C 74 7C 84 88
8C 98 A0 A4 A8 AC B0 B4 B8 BC C0 C4 C8 CC D0 D4
D8 DC

// File: tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core;

	localparam int data_base  = 'h080; // initial data words
	localparam int store_base = 'h0c0; // store count, then addr/data/strb records
	localparam int fetch_base = 'h180; // fetch count, then addresses
	localparam int idle_limit = 100;

	logic                 clk;
	logic                 rstn;
	logic                 imem_valid;
	logic                 imem_ready;
	logic [`RV_XLEN-1:0]  imem_addr;
	logic                 imem_rsp_valid;
	logic [`RV_XLEN-1:0]  imem_rdata;
	logic                 dmem_valid;
	logic                 dmem_ready;
	logic [`RV_XLEN-1:0]  dmem_addr;
	logic                 dmem_write;
	logic [`RV_LANES-1:0] dmem_strb;
	logic [`RV_XLEN-1:0]  dmem_wdata;
	logic                 dmem_rsp_valid;
	logic [`RV_XLEN-1:0]  dmem_rdata;
	logic                 halted;

	logic [`RV_XLEN-1:0] gold [0:511];
	logic [`RV_XLEN-1:0] imem [0:63];
	logic [`RV_XLEN-1:0] dmem [0:63];
	logic [31:0]         lfsr_state;
	int                  store_cnt;
	int                  store_idx;
	int                  fetch_cnt;
	int                  fetch_idx;

	rv_core uut (
		.clk(clk), .rstn(rstn),
		.imem_valid(imem_valid), .imem_ready(imem_ready), .imem_addr(imem_addr),
		.imem_rsp_valid(imem_rsp_valid), .imem_rdata(imem_rdata),
		.dmem_valid(dmem_valid), .dmem_ready(dmem_ready), .dmem_addr(dmem_addr),
		.dmem_write(dmem_write), .dmem_strb(dmem_strb), .dmem_wdata(dmem_wdata),
		.dmem_rsp_valid(dmem_rsp_valid), .dmem_rdata(dmem_rdata),
		.halted(halted)
	);

	always #5 clk = ~clk;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_delay(output int d);
		d = 0;
		repeat (2) begin
			lfsr_state = lfsr_next(lfsr_state);
			d = (d << 1) | lfsr_state[0];
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
		input logic [`RV_XLEN-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic check_strb(input string name, input logic [`RV_LANES-1:0] got,
		input logic [`RV_LANES-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// request first seen at this edge
	task automatic serve_fetch;
		int                  d;
		logic [`RV_XLEN-1:0] addr;
		logic [`RV_XLEN-1:0] exp;
		addr = imem_addr;
		if (fetch_idx >= fetch_cnt)
			abort_run("instruction request past the end of the expected address list");
		exp = gold[fetch_base + 1 + fetch_idx];
		check_word("imem_addr", addr, exp);
		fetch_idx++;
		draw_delay(d);
		repeat (d) @(posedge clk);
		imem_ready <= 1'b1;
		@(posedge clk);
		imem_ready <= 1'b0;
		check_bit("imem_valid", imem_valid, 1'b1); // still requesting at the transfer
		check_word("imem_addr", imem_addr, exp);
		draw_delay(d);
		repeat (d) @(posedge clk);
		imem_rsp_valid <= 1'b1;
		imem_rdata     <= imem[addr[7:2]];
		@(posedge clk);
		imem_rsp_valid <= 1'b0;
	endtask

	task automatic serve_data;
		int                   d;
		int                   rec;
		logic [`RV_XLEN-1:0]  addr;
		logic [`RV_XLEN-1:0]  wdata;
		logic [`RV_LANES-1:0] strb;
		logic [`RV_XLEN-1:0]  word;
		logic                 write;
		addr  = dmem_addr;
		wdata = dmem_wdata;
		strb  = dmem_strb;
		write = dmem_write;
		word  = dmem[addr[7:2]];
		rec   = 0;
		if (write) begin
			if (store_idx >= store_cnt)
				abort_run("more stores than the expected store records");
			rec = store_base + 1 + 3 * store_idx;
			check_word("dmem_addr", addr, gold[rec]);
			check_word("dmem_wdata", wdata, gold[rec + 1]);
			check_strb("dmem_strb", strb, gold[rec + 2][`RV_LANES-1:0]);
			store_idx++;
			for (int i = 0; i < `RV_LANES; i++)
				if (strb[`RV_LANES-1-i])
					word[`RV_XLEN-1-8*i -: 8] = wdata[`RV_XLEN-1-8*i -: 8]; // lane 0 on top
			dmem[addr[7:2]] = word;
		end
		draw_delay(d);
		repeat (d) @(posedge clk);
		dmem_ready <= 1'b1;
		@(posedge clk);
		dmem_ready <= 1'b0;
		check_bit("dmem_valid", dmem_valid, 1'b1); // still requesting at the transfer
		if (write) begin
			check_word("dmem_addr", dmem_addr, gold[rec]);
			check_word("dmem_wdata", dmem_wdata, gold[rec + 1]);
			check_strb("dmem_strb", dmem_strb, gold[rec + 2][`RV_LANES-1:0]);
		end
		draw_delay(d);
		repeat (d) @(posedge clk);
		dmem_rsp_valid <= 1'b1;
		dmem_rdata     <= word;
		@(posedge clk);
		dmem_rsp_valid <= 1'b0;
	endtask

	initial begin
		int idle;
		clk            = 1'b0;
		rstn           <= 1'b0;
		imem_ready     <= 1'b0;
		imem_rsp_valid <= 1'b0;
		imem_rdata     <= '0;
		dmem_ready     <= 1'b0;
		dmem_rsp_valid <= 1'b0;
		dmem_rdata     <= '0;
		lfsr_state     = 32'h8ebe;
		store_idx      = 0;
		fetch_idx      = 0;
		idle           = 0;
		for (int i = 0; i < 512; i++)
			gold[i] = '0;
		$readmemh("tb_golden.txt", gold);
		for (int i = 0; i < 64; i++) begin
			imem[i] = gold[i];
			dmem[i] = gold[data_base + i];
		end
		store_cnt = gold[store_base];
		fetch_cnt = gold[fetch_base];

		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		check_bit("imem_valid", imem_valid, 1'b0);
		check_bit("dmem_valid", dmem_valid, 1'b0);
		check_bit("halted", halted, 1'b0);

		while (!halted) begin
			@(posedge clk);
			if (imem_valid) begin
				serve_fetch();
				idle = 0;
			end else if (dmem_valid) begin
				serve_data();
				idle = 0;
			end else begin
				idle++;
				if (idle > idle_limit)
					abort_run("timed out waiting for a memory request or for halt");
			end
		end

		check_word("store count", store_idx, store_cnt);
		check_word("fetch count", fetch_idx, fetch_cnt);
		repeat (20) begin // stays quiet after ecall
			@(posedge clk);
			check_bit("imem_valid", imem_valid, 1'b0);
			check_bit("dmem_valid", dmem_valid, 1'b0);
			check_bit("halted", halted, 1'b1);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
